//--- hw/pmp_pkg.sv
package pmp_pkg;

  // First CSR numbers of the pmpcfg and pmpaddr banks
  localparam logic [11:0] CSR_PMPCFG0  = 12'h3A0;
  localparam logic [11:0] CSR_PMPADDR0 = 12'h3B0;

  // Bit positions inside one cfg byte
  localparam int CFG_R    = 0;
  localparam int CFG_W    = 1;
  localparam int CFG_X    = 2;
  localparam int CFG_A_LO = 3;
  localparam int CFG_A_HI = 4;
  localparam int CFG_L    = 7;

  // Address matching modes of the A field
  localparam logic [1:0] MODE_OFF   = 2'b00;
  localparam logic [1:0] MODE_TOR   = 2'b01;
  localparam logic [1:0] MODE_NA4   = 2'b10;
  localparam logic [1:0] MODE_NAPOT = 2'b11;

  // Access types of a check request
  localparam logic [1:0] ACC_EXEC  = 2'b00;
  localparam logic [1:0] ACC_LOAD  = 2'b01;
  localparam logic [1:0] ACC_STORE = 2'b10;

  // Privilege levels
  localparam logic [1:0] PRIV_U = 2'b00;
  localparam logic [1:0] PRIV_M = 2'b11;

  // Access fault exception causes
  localparam logic [5:0] CAUSE_INSTR_ACC = 6'd1;
  localparam logic [5:0] CAUSE_LOAD_ACC  = 6'd5;
  localparam logic [5:0] CAUSE_STORE_ACC = 6'd7;

  // One pmpcfg CSR, seen as a word or as four entry bytes
  // Byte 0 sits in bits 7:0 and belongs to the lowest entry of the group
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] bytes;
  } pmp_cfg_word_u;

endpackage

//--- hw/pmp_if.sv
// CSR access path from the control block into the entry registers
interface pmp_csr_if #(
  parameter int NUM_REGIONS = 4
);
  localparam int IDX_W = $clog2(NUM_REGIONS);

  logic             wr_en;
  logic             sel_addr;
  logic [IDX_W-1:0] index;
  logic [31:0]      wdata;
  logic [31:0]      rdata;

  modport master (output wr_en, output sel_addr, output index, output wdata, input rdata);
  modport slave  (input wr_en, input sel_addr, input index, input wdata, output rdata);
endinterface

// Stored entries as seen by the matching pipeline
interface pmp_cfg_if #(
  parameter int NUM_REGIONS = 4
);
  logic [NUM_REGIONS-1:0][7:0]  cfg_bytes;
  logic [NUM_REGIONS-1:0][31:0] addr_words;

  modport source (output cfg_bytes, output addr_words);
  modport sink   (input cfg_bytes, input addr_words);
endinterface

//--- hw/pmp_control.sv
module pmp_control #(
  parameter int NUM_REGIONS = 4
) (
  input  logic        clk_i,
  input  logic        reset_i,

  input  logic        csr_req_valid_i,
  output logic        csr_req_ready_o,
  input  logic [11:0] csr_num_i,
  input  logic        csr_we_i,
  input  logic [31:0] csr_wdata_i,
  input  logic [1:0]  csr_priv_i,

  output logic        csr_rsp_valid_o,
  input  logic        csr_rsp_ready_i,
  output logic [31:0] csr_rsp_rdata_o,
  output logic        csr_rsp_err_o,

  input  logic        chk_req_valid_i,
  output logic        chk_req_ready_o,
  input  logic [31:0] chk_addr_i,
  input  logic [1:0]  chk_type_i,
  input  logic [1:0]  chk_priv_i,

  pmp_csr_if.master   csr_if,

  output logic        s0_valid_o,
  input  logic        s0_ready_i,
  output logic [31:0] s0_addr_o,
  output logic [1:0]  s0_type_o,
  output logic [1:0]  s0_priv_o
);
  import pmp_pkg::*;

  localparam int IDX_W = $clog2(NUM_REGIONS);

  logic        csr_fire;
  logic [11:0] cfg_off;
  logic [11:0] addr_off;
  logic        is_cfg;
  logic        is_addr;
  logic        csr_err;
  logic        rsp_valid_q;
  logic [31:0] rsp_rdata_q;
  logic        rsp_err_q;

  // Offsets wrap below the bank base, so one compare covers both ends
  assign cfg_off  = csr_num_i - CSR_PMPCFG0;
  assign addr_off = csr_num_i - CSR_PMPADDR0;
  assign is_cfg   = cfg_off < 12'(NUM_REGIONS / 4);
  assign is_addr  = addr_off < 12'(NUM_REGIONS);
  assign csr_err  = (csr_priv_i != PRIV_M) || !(is_cfg || is_addr);

  // Only one CSR operation in flight
  assign csr_req_ready_o = !rsp_valid_q;
  assign csr_fire        = csr_req_valid_i && csr_req_ready_o;

  assign csr_if.wr_en    = csr_fire && csr_we_i && !csr_err;
  assign csr_if.sel_addr = is_addr;
  // Both bank bases are 16-aligned, so the low number bits give the index
  assign csr_if.index    = csr_num_i[IDX_W-1:0];
  assign csr_if.wdata    = csr_wdata_i;

  // CSR wins the cycle; a blocked CSR request lets the check through
  assign s0_valid_o      = chk_req_valid_i && !csr_fire;
  assign chk_req_ready_o = s0_ready_i && !csr_fire;
  assign s0_addr_o       = chk_addr_i;
  assign s0_type_o       = chk_type_i;
  assign s0_priv_o       = chk_priv_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (csr_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (csr_rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Read data is the value before a write in the same request
  always_ff @(posedge clk_i) begin
    if (csr_fire) begin
      rsp_rdata_q <= csr_err ? 32'd0 : csr_if.rdata;
      rsp_err_q   <= csr_err;
    end
  end

  assign csr_rsp_valid_o = rsp_valid_q;
  assign csr_rsp_rdata_o = rsp_rdata_q;
  assign csr_rsp_err_o   = rsp_err_q;

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    csr_rsp_valid_o && !csr_rsp_ready_i |=>
      csr_rsp_valid_o && $stable(csr_rsp_rdata_o) && $stable(csr_rsp_err_o));

  a_no_umode_write: assert property (@(posedge clk_i) disable iff (reset_i)
    csr_req_valid_i && (csr_priv_i == PRIV_U) |-> !csr_if.wr_en);

endmodule

//--- hw/pmp_region_store.sv
module pmp_region_store #(
  parameter int NUM_REGIONS = 4,
  parameter int GRANULARITY = 0
) (
  input  logic      clk_i,
  input  logic      reset_i,
  pmp_csr_if.slave  csr_if,
  pmp_cfg_if.source cfg_if
);
  import pmp_pkg::*;

  // Read-back masks for the granularity rule
  localparam logic [31:0] NAPOT_ONES =
    (GRANULARITY >= 2) ? ((32'd1 << (GRANULARITY - 1)) - 32'd1) : 32'd0;
  localparam logic [31:0] OFF_ZEROS =
    (GRANULARITY >= 1) ? ((32'd1 << GRANULARITY) - 32'd1) : 32'd0;

  logic [NUM_REGIONS-1:0][7:0]  cfg_q;
  logic [NUM_REGIONS-1:0][31:0] addr_q;
  logic [NUM_REGIONS-1:0]       addr_locked;
  pmp_cfg_word_u                wr_word;
  pmp_cfg_word_u                rd_word;
  logic [31:0]                  addr_rd;

  // Turns a written cfg byte into a legal one
  function automatic logic [7:0] legal_cfg(input logic [7:0] old_cfg,
                                           input logic [7:0] new_cfg);
    logic [7:0] res;
    res = new_cfg;
    // W without R is reserved
    if (new_cfg[CFG_W] && !new_cfg[CFG_R]) begin
      res[CFG_X:CFG_R] = old_cfg[CFG_X:CFG_R];
    end
    if ((GRANULARITY >= 1) && (new_cfg[CFG_A_HI:CFG_A_LO] == MODE_NA4)) begin
      res[CFG_A_HI:CFG_A_LO] = old_cfg[CFG_A_HI:CFG_A_LO];
    end
    res[6:5] = 2'b00;
    if (old_cfg[CFG_L]) begin
      res = old_cfg;
    end
    return res;
  endfunction

  // NA4 never exists with G>=1, so the top mode bit selects the rule
  function automatic logic [31:0] addr_view(input logic [7:0] cfg, input logic [31:0] addr);
    if (cfg[CFG_A_HI]) begin
      return addr | NAPOT_ONES;
    end
    return addr & ~OFF_ZEROS;
  endfunction

  // An address is frozen by its own lock or by a locked TOR entry above it
  for (genvar i = 0; i < NUM_REGIONS; i++) begin : gen_addr_lock
    if (i < NUM_REGIONS - 1) begin : gen_above
      assign addr_locked[i] = cfg_q[i][CFG_L] ||
        (cfg_q[i+1][CFG_L] && (cfg_q[i+1][CFG_A_HI:CFG_A_LO] == MODE_TOR));
    end else begin : gen_last
      assign addr_locked[i] = cfg_q[i][CFG_L];
    end
  end

  assign wr_word.word = csr_if.wdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q  <= '0;
      addr_q <= '0;
    end else if (csr_if.wr_en) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (!csr_if.sel_addr && (i / 4 == int'(csr_if.index))) begin
          cfg_q[i] <= legal_cfg(cfg_q[i], wr_word.bytes[i % 4]);
        end
        if (csr_if.sel_addr && (i == int'(csr_if.index)) && !addr_locked[i]) begin
          addr_q[i] <= csr_if.wdata;
        end
      end
    end
  end

  // Combinational read of the selected CSR
  always_comb begin
    rd_word.word = '0;
    addr_rd      = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (i / 4 == int'(csr_if.index)) begin
        rd_word.bytes[i % 4] = cfg_q[i];
      end
      if (i == int'(csr_if.index)) begin
        addr_rd = addr_view(cfg_q[i], addr_q[i]);
      end
    end
  end

  assign csr_if.rdata      = csr_if.sel_addr ? addr_rd : rd_word.word;
  assign cfg_if.cfg_bytes  = cfg_q;
  assign cfg_if.addr_words = addr_q;

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : gen_checks
    a_locked_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      cfg_q[i][CFG_L] |=> $stable(cfg_q[i]) && $stable(addr_q[i]));

    a_zero_bits: assert property (@(posedge clk_i) disable iff (reset_i)
      cfg_q[i][6:5] == 2'b00);
  end

endmodule

//--- hw/pmp_match.sv
module pmp_match #(
  parameter int NUM_REGIONS = 4,
  parameter int GRANULARITY = 0
) (
  input  logic        clk_i,
  input  logic        reset_i,

  input  logic        s0_valid_i,
  output logic        s0_ready_o,
  input  logic [31:0] s0_addr_i,
  input  logic [1:0]  s0_type_i,
  input  logic [1:0]  s0_priv_i,

  pmp_cfg_if.sink     cfg_if,

  output logic        chk_rsp_valid_o,
  input  logic        chk_rsp_ready_i,
  output logic        chk_rsp_allow_o,
  output logic [5:0]  chk_rsp_cause_o
);
  import pmp_pkg::*;

  localparam logic [31:0] NAPOT_ONES =
    (GRANULARITY >= 2) ? ((32'd1 << (GRANULARITY - 1)) - 32'd1) : 32'd0;
  localparam logic [31:0] OFF_ZEROS =
    (GRANULARITY >= 1) ? ((32'd1 << GRANULARITY) - 32'd1) : 32'd0;

  logic [31:0]            word_addr;
  logic [NUM_REGIONS-1:0] match_d;
  logic [NUM_REGIONS-1:0] perm_d;
  logic [NUM_REGIONS-1:0] lock_d;

  logic                   s1_valid_q;
  logic [NUM_REGIONS-1:0] s1_match_q;
  logic [NUM_REGIONS-1:0] s1_perm_q;
  logic [NUM_REGIONS-1:0] s1_lock_q;
  logic [1:0]             s1_type_q;
  logic [1:0]             s1_priv_q;
  logic                   s1_ready;

  logic                   hit;
  logic                   sel_perm;
  logic                   sel_lock;
  logic                   allow_d;
  logic [5:0]             cause_d;
  logic                   out_ready;
  logic                   rsp_valid_q;
  logic                   rsp_allow_q;
  logic [5:0]             rsp_cause_q;

  assign word_addr = {2'b00, s0_addr_i[31:2]};

  // Stage 1 works on the entries as they are at acceptance
  always_comb begin
    logic [31:0] prev_addr;
    logic [31:0] napot_addr;
    logic [31:0] care;
    prev_addr = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      napot_addr = cfg_if.addr_words[i] | NAPOT_ONES;
      // Trailing ones and the zero above them are don't-care bits
      care = ~(napot_addr ^ (napot_addr + 32'd1));
      case (cfg_if.cfg_bytes[i][CFG_A_HI:CFG_A_LO])
        MODE_TOR:   match_d[i] = (word_addr >= (prev_addr & ~OFF_ZEROS)) &&
                                 (word_addr < (cfg_if.addr_words[i] & ~OFF_ZEROS));
        MODE_NA4:   match_d[i] = word_addr == cfg_if.addr_words[i];
        MODE_NAPOT: match_d[i] = ((word_addr ^ napot_addr) & care) == 32'd0;
        default:    match_d[i] = 1'b0;
      endcase
      case (s0_type_i)
        ACC_EXEC:  perm_d[i] = cfg_if.cfg_bytes[i][CFG_X];
        ACC_LOAD:  perm_d[i] = cfg_if.cfg_bytes[i][CFG_R];
        ACC_STORE: perm_d[i] = cfg_if.cfg_bytes[i][CFG_W];
        default:   perm_d[i] = 1'b0;
      endcase
      lock_d[i] = cfg_if.cfg_bytes[i][CFG_L];
      prev_addr = cfg_if.addr_words[i];
    end
  end

  // Stage 2, lowest-numbered match wins
  always_comb begin
    hit      = 1'b0;
    sel_perm = 1'b0;
    sel_lock = 1'b0;
    for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
      if (s1_match_q[i]) begin
        hit      = 1'b1;
        sel_perm = s1_perm_q[i];
        sel_lock = s1_lock_q[i];
      end
    end
    if (!hit) begin
      allow_d = s1_priv_q == PRIV_M;
    end else if (s1_priv_q == PRIV_M) begin
      allow_d = !sel_lock || sel_perm;
    end else begin
      allow_d = sel_perm;
    end
    case (s1_type_q)
      ACC_EXEC: cause_d = CAUSE_INSTR_ACC;
      ACC_LOAD: cause_d = CAUSE_LOAD_ACC;
      default:  cause_d = CAUSE_STORE_ACC;
    endcase
    if (allow_d) begin
      cause_d = 6'd0;
    end
  end

  assign out_ready  = !rsp_valid_q || chk_rsp_ready_i;
  assign s1_ready   = !s1_valid_q || out_ready;
  assign s0_ready_o = s1_ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_valid_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= s0_valid_i;
      end
      if (out_ready) begin
        rsp_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (s0_valid_i && s1_ready) begin
      s1_match_q <= match_d;
      s1_perm_q  <= perm_d;
      s1_lock_q  <= lock_d;
      s1_type_q  <= s0_type_i;
      s1_priv_q  <= s0_priv_i;
    end
    if (s1_valid_q && out_ready) begin
      rsp_allow_q <= allow_d;
      rsp_cause_q <= cause_d;
    end
  end

  assign chk_rsp_valid_o = rsp_valid_q;
  assign chk_rsp_allow_o = rsp_allow_q;
  assign chk_rsp_cause_o = rsp_cause_q;

  a_allow_no_cause: assert property (@(posedge clk_i) disable iff (reset_i)
    chk_rsp_valid_o && chk_rsp_allow_o |-> chk_rsp_cause_o == 6'd0);

endmodule

//--- hw/pmp_top.sv
module pmp_top #(
  parameter int NUM_REGIONS = 4,
  parameter int GRANULARITY = 0
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        csr_req_valid_i,
  output logic        csr_req_ready_o,
  input  logic [11:0] csr_num_i,
  input  logic        csr_we_i,
  input  logic [31:0] csr_wdata_i,
  input  logic [1:0]  csr_priv_i,
  output logic        csr_rsp_valid_o,
  input  logic        csr_rsp_ready_i,
  output logic [31:0] csr_rsp_rdata_o,
  output logic        csr_rsp_err_o,
  input  logic        chk_req_valid_i,
  output logic        chk_req_ready_o,
  input  logic [31:0] chk_addr_i,
  input  logic [1:0]  chk_type_i,
  input  logic [1:0]  chk_priv_i,
  output logic        chk_rsp_valid_o,
  input  logic        chk_rsp_ready_i,
  output logic        chk_rsp_allow_o,
  output logic [5:0]  chk_rsp_cause_o
);
  logic        s0_valid;
  logic        s0_ready;
  logic [31:0] s0_addr;
  logic [1:0]  s0_type;
  logic [1:0]  s0_priv;

  pmp_csr_if #(.NUM_REGIONS(NUM_REGIONS)) csr_if ();
  pmp_cfg_if #(.NUM_REGIONS(NUM_REGIONS)) cfg_if ();

  pmp_control #(
    .NUM_REGIONS(NUM_REGIONS)
  ) u_control (
    .clk_i, .reset_i,
    .csr_req_valid_i, .csr_req_ready_o, .csr_num_i, .csr_we_i, .csr_wdata_i, .csr_priv_i,
    .csr_rsp_valid_o, .csr_rsp_ready_i, .csr_rsp_rdata_o, .csr_rsp_err_o,
    .chk_req_valid_i, .chk_req_ready_o, .chk_addr_i, .chk_type_i, .chk_priv_i,
    .csr_if     (csr_if.master),
    .s0_valid_o (s0_valid),
    .s0_ready_i (s0_ready),
    .s0_addr_o  (s0_addr),
    .s0_type_o  (s0_type),
    .s0_priv_o  (s0_priv)
  );

  pmp_region_store #(
    .NUM_REGIONS(NUM_REGIONS),
    .GRANULARITY(GRANULARITY)
  ) u_region_store (
    .clk_i, .reset_i,
    .csr_if (csr_if.slave),
    .cfg_if (cfg_if.source)
  );

  pmp_match #(
    .NUM_REGIONS(NUM_REGIONS),
    .GRANULARITY(GRANULARITY)
  ) u_match (
    .clk_i, .reset_i,
    .s0_valid_i (s0_valid),
    .s0_ready_o (s0_ready),
    .s0_addr_i  (s0_addr),
    .s0_type_i  (s0_type),
    .s0_priv_i  (s0_priv),
    .cfg_if     (cfg_if.sink),
    .chk_rsp_valid_o, .chk_rsp_ready_i, .chk_rsp_allow_o, .chk_rsp_cause_o
  );

endmodule

//--- sim/tb_pmp_top.sv
module tb_pmp_top;

  localparam int TIMEOUT = 200;

  logic        clk_i = 1'b0;
  logic        reset_i;
  logic        csr_req_valid_i;
  logic        csr_req_ready_o;
  logic [11:0] csr_num_i;
  logic        csr_we_i;
  logic [31:0] csr_wdata_i;
  logic [1:0]  csr_priv_i;
  logic        csr_rsp_valid_o;
  logic        csr_rsp_ready_i;
  logic [31:0] csr_rsp_rdata_o;
  logic        csr_rsp_err_o;
  logic        chk_req_valid_i;
  logic        chk_req_ready_o;
  logic [31:0] chk_addr_i;
  logic [1:0]  chk_type_i;
  logic [1:0]  chk_priv_i;
  logic        chk_rsp_valid_o;
  logic        chk_rsp_ready_i;
  logic        chk_rsp_allow_o;
  logic [5:0]  chk_rsp_cause_o;

  // Expected responses, oldest first
  logic [31:0] exp_rdata_q[$];
  logic        exp_err_q[$];
  bit          data_chk_q[$];
  logic        exp_allow_q[$];
  logic [5:0]  exp_cause_q[$];

  pmp_top #(
    .NUM_REGIONS(4),
    .GRANULARITY(2)
  ) u_pmp_top (.*);

  always #20 clk_i = ~clk_i;

  task automatic report_error(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    report_error($sformatf("FAIL at time %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic compare_csr(input logic [31:0] rdata, input logic err,
                             input logic [31:0] exp_rdata, input logic exp_err,
                             input bit use_data);
    if (err !== exp_err) begin
      report_mismatch("csr_rsp_err_o", 32'(err), 32'(exp_err));
    end
    // Write responses carry the old value, not checked here
    if (use_data && (rdata !== exp_rdata)) begin
      report_mismatch("csr_rsp_rdata_o", rdata, exp_rdata);
    end
  endtask

  task automatic compare_chk(input logic allow, input logic [5:0] cause,
                             input logic exp_allow, input logic [5:0] exp_cause);
    if (allow !== exp_allow) begin
      report_mismatch("chk_rsp_allow_o", 32'(allow), 32'(exp_allow));
    end
    if (cause !== exp_cause) begin
      report_mismatch("chk_rsp_cause_o", 32'(cause), 32'(exp_cause));
    end
  endtask

  task automatic send_csr(input logic [11:0] num, input logic we, input logic [31:0] wdata,
                          input logic [1:0] priv);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    csr_req_valid_i <= 1'b1;
    csr_num_i       <= num;
    csr_we_i        <= we;
    csr_wdata_i     <= wdata;
    csr_priv_i      <= priv;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_error("CSR request was not accepted in time");
      end
    end while (!csr_req_ready_o);
    @(posedge clk_i);
    csr_req_valid_i <= 1'b0;
  endtask

  task automatic send_chk(input logic [31:0] addr, input logic [1:0] acc,
                          input logic [1:0] priv);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    chk_req_valid_i <= 1'b1;
    chk_addr_i      <= addr;
    chk_type_i      <= acc;
    chk_priv_i      <= priv;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_error("check request was not accepted in time");
      end
    end while (!chk_req_ready_o);
    @(posedge clk_i);
    chk_req_valid_i <= 1'b0;
  endtask

  // Handshakes sampled half a cycle before the edge that completes them
  always @(negedge clk_i) begin
    if (!reset_i && csr_rsp_valid_o && csr_rsp_ready_i) begin
      if (exp_err_q.size() == 0) begin
        report_error("CSR response arrived with no request pending");
      end
      compare_csr(csr_rsp_rdata_o, csr_rsp_err_o, exp_rdata_q.pop_front(),
                  exp_err_q.pop_front(), data_chk_q.pop_front());
    end
  end

  always @(negedge clk_i) begin
    if (!reset_i && chk_rsp_valid_o && chk_rsp_ready_i) begin
      if (exp_allow_q.size() == 0) begin
        report_error("check response arrived with no request pending");
      end
      compare_chk(chk_rsp_allow_o, chk_rsp_cause_o, exp_allow_q.pop_front(),
                  exp_cause_q.pop_front());
    end
  end

  // Random back-pressure on both response ports
  initial begin
    void'($urandom(56));
    csr_rsp_ready_i <= 1'b1;
    chk_rsp_ready_i <= 1'b1;
    forever begin
      @(posedge clk_i);
      csr_rsp_ready_i <= ($urandom % 4) != 0;
      chk_rsp_ready_i <= ($urandom % 3) != 0;
    end
  end

  initial begin
    int          fd;
    int          ops;
    int          cycles;
    string       line;
    logic [31:0] kind, a, b, c, d, e;
    reset_i         <= 1'b1;
    csr_req_valid_i <= 1'b0;
    csr_num_i       <= '0;
    csr_we_i        <= 1'b0;
    csr_wdata_i     <= '0;
    csr_priv_i      <= '0;
    chk_req_valid_i <= 1'b0;
    chk_addr_i      <= '0;
    chk_type_i      <= '0;
    chk_priv_i      <= '0;
    ops = 0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;

    fd = $fopen("sim/pmp_patterns.txt", "r");
    if (fd == 0) begin
      report_error("could not open sim/pmp_patterns.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if ((line.len() < 2) || (line.getc(0) == "#")) begin
        continue;
      end
      if ($sscanf(line, "%h %h %h %h %h %h", kind, a, b, c, d, e) != 6) begin
        report_error({"malformed line in pattern file: ", line});
      end
      ops++;
      case (kind)
        0: begin
          exp_rdata_q.push_back(32'd0);
          exp_err_q.push_back(d[0]);
          data_chk_q.push_back(1'b0);
          send_csr(a[11:0], 1'b1, b, c[1:0]);
        end
        1: begin
          exp_rdata_q.push_back(b);
          exp_err_q.push_back(d[0]);
          data_chk_q.push_back(1'b1);
          send_csr(a[11:0], 1'b0, 32'd0, c[1:0]);
        end
        2: begin
          exp_allow_q.push_back(d[0]);
          exp_cause_q.push_back(e[5:0]);
          send_chk(a, b[1:0], c[1:0]);
        end
        default: report_error("unknown operation kind in pattern file");
      endcase
    end
    $fclose(fd);
    if (ops == 0) begin
      report_error("pattern file held no operations");
    end

    // Let the last responses drain
    cycles = 0;
    while ((exp_err_q.size() != 0) || (exp_allow_q.size() != 0)) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_error("responses still missing at end of run");
      end
    end
    $display("Everything OK");
    $finish;
  end

endmodule

//--- sim/pmp_patterns.txt
# kind 0 write: csr_num wdata priv exp_err 0 | kind 1 read: csr_num exp_rdata priv exp_err 0
# kind 2 check: addr type priv exp_allow exp_cause | all hex, priv 0=U 3=M, type 0=X 1=R 2=W
1 3A0 00000000 3 0 00
0 3B0 12345678 0 1 00
1 3B0 00000000 3 0 00
1 3A0 00000000 0 1 00
0 3A1 FFFFFFFF 3 1 00
1 3B4 00000000 3 1 00
2 00001000 1 0 0 05
2 00001000 2 3 1 00
0 3A0 00000019 3 0 00
0 3A0 00000076 3 0 00
1 3A0 00000019 3 0 00
0 3B0 00000402 3 0 00
1 3B0 00000403 3 0 00
0 3B0 00000403 3 0 00
0 3A0 00000008 3 0 00
1 3B0 00000400 3 0 00
0 3A0 00000019 3 0 00
1 3B0 00000403 3 0 00
0 3B1 00000800 3 0 00
0 3B2 00001001 3 0 00
0 3A0 001C0B19 3 0 00
2 00001000 1 0 1 00
2 00001000 2 0 0 07
2 00001020 2 0 1 00
2 00001800 0 0 0 01
2 00004004 0 0 1 00
2 00004004 1 0 0 05
2 00002000 1 0 0 05
2 00001800 0 3 1 00
0 3A0 001C8B19 3 0 00
0 3A0 001C0F19 3 0 00
1 3A0 001C8B19 3 0 00
0 3B1 00000900 3 0 00
1 3B1 00000800 3 0 00
0 3B0 00000500 3 0 00
1 3B0 00000403 3 0 00
0 3B2 00001003 3 0 00
1 3B2 00001003 3 0 00
2 00001800 0 3 0 01
2 00001800 1 3 1 00
2 00001000 2 3 1 00
2 00004004 0 0 1 00
2 00008000 2 0 0 07

//--- build.f
hw/pmp_pkg.sv
hw/pmp_if.sv
hw/pmp_control.sv
hw/pmp_region_store.sv
hw/pmp_match.sv
hw/pmp_top.sv
sim/tb_pmp_top.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the PMP testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f build.f \
  --top-module tb_pmp_top \
  -o tb_pmp_top

./obj_dir/tb_pmp_top
